//--- hw/bus_defs.svh
// CPU bus front end build constants
// memory depth, status identification and input timing option

`ifndef BUS_DEFS_SVH
`define BUS_DEFS_SVH

// work RAM depth in 32-bit words, addresses above this alias
`define BUS_RAM_WORDS 256

// constant returned by status word 2
`define BUS_STATUS_ID 32'h5c0b_0001

// 1 adds a register stage on the CPU request inputs
// ready then comes two cycles after the sampling edge instead of one
`define BUS_REGISTERED_INPUTS 1

`endif

//--- hw/bus_pkg.sv
// CPU bus front end types
// address, data, strobe and decoded region shared by all blocks

`default_nettype none

package bus_pkg;

    // byte address, bit 19 selects flash and 18:16 hold the region field
    typedef logic [19:0] bus_addr_t;

    // one bus word for both directions
    typedef logic [31:0] bus_data_t;

    // byte write strobes, any bit set marks a write
    typedef logic [3:0] bus_strb_t;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // decoded target of one access
    // ram to pad share their values with the region field codes
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    typedef enum logic [2:0] {
        region_ram    = 3'd0,
        region_vdp    = 3'd1,
        region_status = 3'd2,
        region_dsp    = 3'd3,
        region_pad    = 3'd4,
        region_flash  = 3'd5,
        region_none   = 3'd7
    } region_e;

endpackage

`default_nettype wire

//--- hw/cpu_bus_if.sv
// captured CPU request
// one held transaction as seen by the decoder and the internal targets

`timescale 1ns/1ps
`default_nettype none

interface cpu_bus_if;

    import bus_pkg::*;

    bus_addr_t address;
    bus_data_t wdata;
    bus_strb_t wstrb;

    // high while the held request is being served
    logic      active;

    modport source (
        output address,
        output wdata,
        output wstrb,
        output active
    );

    modport sink (
        input address,
        input wdata,
        input wstrb,
        input active
    );

endinterface

`default_nettype wire

//--- hw/bus_capture.sv
// request capture
// takes one CPU request, optionally through an input register, and
// marks it active for a single cycle while holding it until done

`timescale 1ns/1ps
`default_nettype none

module bus_capture #(
    parameter bit registered_inputs = 1'b1
) (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 cpu_mem_valid,
    input  bus_pkg::bus_addr_t  cpu_mem_address,
    input  bus_pkg::bus_data_t  cpu_mem_wdata,
    input  bus_pkg::bus_strb_t  cpu_mem_wstrb,
    input  wire                 done,
    cpu_bus_if.source           req
);

    import bus_pkg::*;

    // set while a request is held, so a held valid is taken once
    logic busy;

    generate
        if (registered_inputs) begin : g_registered
            bus_addr_t address_q;
            bus_data_t wdata_q;
            bus_strb_t wstrb_q;
            logic      active_q;
            logic      take;

            assign take = cpu_mem_valid && !busy && !done;

            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    active_q <= 1'b0;
                    busy     <= 1'b0;
                end else begin
                    active_q <= take;
                    if (take) begin
                        busy <= 1'b1;
                    end else if (done) begin
                        busy <= 1'b0;
                    end
                end
            end

            always_ff @(posedge clk) begin
                if (take) begin
                    address_q <= cpu_mem_address;
                    wdata_q   <= cpu_mem_wdata;
                    wstrb_q   <= cpu_mem_wstrb;
                end
            end

            assign req.address = address_q;
            assign req.wdata   = wdata_q;
            assign req.wstrb   = wstrb_q;
            assign req.active  = active_q;
        end else begin : g_direct
            // CPU holds the request steady, only the active window is gated
            assign req.address = cpu_mem_address;
            assign req.wdata   = cpu_mem_wdata;
            assign req.wstrb   = cpu_mem_wstrb;
            assign req.active  = cpu_mem_valid && !busy && !done;

            // released once the CPU drops valid after ready
            always_ff @(posedge clk or negedge arst_n) begin
                if (!arst_n) begin
                    busy <= 1'b0;
                end else if (req.active) begin
                    busy <= 1'b1;
                end else if (!cpu_mem_valid) begin
                    busy <= 1'b0;
                end
            end
        end
    endgenerate

endmodule

`default_nettype wire

//--- hw/address_decoder.sv
// address decoder
// maps the active request to a region and raises the matching
// internal enable or external enable and write enable pair

`timescale 1ns/1ps
`default_nettype none

module address_decoder (
    cpu_bus_if.sink           req,
    output bus_pkg::region_e  region,
    output logic              ram_en,
    output logic              status_en,
    output logic              vdp_en,
    output logic              vdp_write_en,
    output logic              dsp_en,
    output logic              dsp_write_en,
    output logic              pad_en,
    output logic              pad_write_en,
    output logic              flash_read_en
);

    import bus_pkg::*;

    logic is_write;

    assign is_write = |req.wstrb;

    // region is decoded from the address alone, enables need active
    always_comb begin
        if (req.address[19]) begin
            region = region_flash;
        end else begin
            case (req.address[18:16])
                3'd0:    region = region_ram;
                3'd1:    region = region_vdp;
                3'd2:    region = region_status;
                3'd3:    region = region_dsp;
                3'd4:    region = region_pad;
                default: region = region_none;
            endcase
        end
    end

    always_comb begin
        ram_en        = 1'b0;
        status_en     = 1'b0;
        vdp_en        = 1'b0;
        dsp_en        = 1'b0;
        pad_en        = 1'b0;
        flash_read_en = 1'b0;

        if (req.active) begin
            case (region)
                region_ram:    ram_en = 1'b1;
                region_status: status_en = 1'b1;
                region_vdp:    vdp_en = 1'b1;
                region_dsp:    dsp_en = 1'b1;
                region_pad:    pad_en = 1'b1;
                // flash is read only, a write just shows up as a read enable
                region_flash:  flash_read_en = 1'b1;
                default: begin
                end
            endcase
        end
    end

    assign vdp_write_en = vdp_en && is_write;
    assign dsp_write_en = dsp_en && is_write;
    assign pad_write_en = pad_en && is_write;

endmodule

`default_nettype wire

//--- hw/work_ram.sv
// work RAM
// byte strobed synchronous RAM serving region 0, registered read

`timescale 1ns/1ps
`default_nettype none

`include "bus_defs.svh"

module work_ram (
    input  wire                 clk,
    cpu_bus_if.sink             req,
    input  wire                 ram_en,
    output bus_pkg::bus_data_t  rdata
);

    import bus_pkg::*;

    localparam int ram_aw = $clog2(`BUS_RAM_WORDS);

    bus_data_t         mem [`BUS_RAM_WORDS];
    logic [ram_aw-1:0] word_index;
    logic              is_write;

    // upper address bits are ignored, so the RAM repeats through region 0
    assign word_index = req.address[ram_aw+1:2];
    assign is_write   = |req.wstrb;

    always_ff @(posedge clk) begin
        if (ram_en && is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b]) begin
                    mem[word_index][b*8 +: 8] <= req.wdata[b*8 +: 8];
                end
            end
        end
    end

    // read port sees the contents from before a same cycle write
    always_ff @(posedge clk) begin
        if (ram_en) begin
            rdata <= mem[word_index];
        end
    end

endmodule

`default_nettype wire

//--- hw/status_regs.sv
// status register block
// scratch and control words, a fixed ID word and a count of
// completed writes to any mapped region

`timescale 1ns/1ps
`default_nettype none

`include "bus_defs.svh"

module status_regs (
    input  wire                 clk,
    input  wire                 arst_n,
    cpu_bus_if.sink             req,
    input  wire                 status_en,
    input  wire                 done,
    output bus_pkg::bus_data_t  rdata
);

    import bus_pkg::*;

    bus_data_t  scratch;
    bus_data_t  control;
    bus_data_t  write_count;
    logic [1:0] word_sel;
    logic       is_write;
    logic       mapped;
    logic       count_pending;

    assign word_sel = req.address[3:2];
    assign is_write = |req.wstrb;

    // flash and region codes 0 to 4 each raise an enable
    assign mapped = req.address[19] || (req.address[18:16] <= 3'd4);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            scratch <= '0;
            control <= '0;
        end else if (status_en && is_write) begin
            for (int b = 0; b < 4; b++) begin
                if (req.wstrb[b] && word_sel == 2'd0) begin
                    scratch[b*8 +: 8] <= req.wdata[b*8 +: 8];
                end
                if (req.wstrb[b] && word_sel == 2'd1) begin
                    control[b*8 +: 8] <= req.wdata[b*8 +: 8];
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // write counter, armed in the active cycle and bumped on done
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            count_pending <= 1'b0;
            write_count   <= '0;
        end else begin
            if (req.active) begin
                count_pending <= is_write && mapped;
            end else if (done) begin
                count_pending <= 1'b0;
            end
            if (done && count_pending) begin
                write_count <= write_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (status_en) begin
            case (word_sel)
                2'd0:    rdata <= scratch;
                2'd1:    rdata <= control;
                2'd2:    rdata <= `BUS_STATUS_ID;
                default: rdata <= write_count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/read_return.sv
// read return path
// times the ready pulse and picks the read data and error flag
// for the transaction that was just active

`timescale 1ns/1ps
`default_nettype none

module read_return (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 active,
    input  bus_pkg::region_e    region,
    input  bus_pkg::bus_data_t  ram_rdata,
    input  bus_pkg::bus_data_t  status_rdata,
    input  bus_pkg::bus_data_t  ext_rdata,
    output logic                done,
    output logic                cpu_mem_ready,
    output bus_pkg::bus_data_t  cpu_mem_rdata,
    output logic                cpu_mem_error
);

    import bus_pkg::*;

    region_e   region_q;
    bus_data_t ext_rdata_q;
    logic      active_d;
    logic      done_q;
    logic      start;

    // one pulse per active window, re-armed once active drops
    assign start = active && !active_d;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            active_d <= 1'b0;
            done_q   <= 1'b0;
            region_q <= region_none;
        end else begin
            active_d <= active;
            done_q   <= start;
            if (start) begin
                region_q <= region;
            end
        end
    end

    // external devices answer within the enable cycle
    always_ff @(posedge clk) begin
        if (start) begin
            ext_rdata_q <= ext_rdata;
        end
    end

    always_comb begin
        case (region_q)
            region_ram:    cpu_mem_rdata = ram_rdata;
            region_status: cpu_mem_rdata = status_rdata;
            region_none:   cpu_mem_rdata = '0;
            default:       cpu_mem_rdata = ext_rdata_q;
        endcase
    end

    assign done          = done_q;
    assign cpu_mem_ready = done_q;
    assign cpu_mem_error = done_q && (region_q == region_none);

endmodule

`default_nettype wire

//--- hw/cpu_bus_top.sv
// CPU memory bus front end
// captures CPU requests, serves work RAM and status internally and
// drives the remaining regions through shared external strobes

`timescale 1ns/1ps
`default_nettype none

`include "bus_defs.svh"

module cpu_bus_top (
    input  wire                 clk,
    input  wire                 arst_n,
    input  wire                 cpu_mem_valid,
    input  bus_pkg::bus_addr_t  cpu_mem_address,
    input  bus_pkg::bus_data_t  cpu_mem_wdata,
    input  bus_pkg::bus_strb_t  cpu_mem_wstrb,
    output logic                cpu_mem_ready,
    output bus_pkg::bus_data_t  cpu_mem_rdata,
    output logic                cpu_mem_error,
    output bus_pkg::bus_addr_t  ext_address,
    output bus_pkg::bus_data_t  ext_wdata,
    output bus_pkg::bus_strb_t  ext_wstrb,
    output logic                vdp_en,
    output logic                vdp_write_en,
    output logic                dsp_en,
    output logic                dsp_write_en,
    output logic                pad_en,
    output logic                pad_write_en,
    output logic                flash_read_en,
    input  bus_pkg::bus_data_t  ext_rdata
);

    import bus_pkg::*;

    cpu_bus_if bus ();

    region_e   region;
    logic      ram_en;
    logic      status_en;
    logic      done;
    bus_data_t ram_rdata;
    bus_data_t status_rdata;

    // shared external bus is the held request
    assign ext_address = bus.address;
    assign ext_wdata   = bus.wdata;
    assign ext_wstrb   = bus.wstrb;

    bus_capture #(
        .registered_inputs (`BUS_REGISTERED_INPUTS)
    ) u_capture (
        .clk             (clk),
        .arst_n          (arst_n),
        .cpu_mem_valid   (cpu_mem_valid),
        .cpu_mem_address (cpu_mem_address),
        .cpu_mem_wdata   (cpu_mem_wdata),
        .cpu_mem_wstrb   (cpu_mem_wstrb),
        .done            (done),
        .req             (bus.source)
    );

    address_decoder u_decoder (
        .req           (bus.sink),
        .region        (region),
        .ram_en        (ram_en),
        .status_en     (status_en),
        .vdp_en        (vdp_en),
        .vdp_write_en  (vdp_write_en),
        .dsp_en        (dsp_en),
        .dsp_write_en  (dsp_write_en),
        .pad_en        (pad_en),
        .pad_write_en  (pad_write_en),
        .flash_read_en (flash_read_en)
    );

    work_ram u_ram (
        .clk    (clk),
        .req    (bus.sink),
        .ram_en (ram_en),
        .rdata  (ram_rdata)
    );

    status_regs u_status (
        .clk       (clk),
        .arst_n    (arst_n),
        .req       (bus.sink),
        .status_en (status_en),
        .done      (done),
        .rdata     (status_rdata)
    );

    read_return u_return (
        .clk           (clk),
        .arst_n        (arst_n),
        .active        (bus.active),
        .region        (region),
        .ram_rdata     (ram_rdata),
        .status_rdata  (status_rdata),
        .ext_rdata     (ext_rdata),
        .done          (done),
        .cpu_mem_ready (cpu_mem_ready),
        .cpu_mem_rdata (cpu_mem_rdata),
        .cpu_mem_error (cpu_mem_error)
    );

endmodule

`default_nettype wire

//--- dv/cpu_bus_tb.sv
// testbench for the CPU bus front end
// random CPU requests checked against a model of RAM, status words,
// region decode, external strobes and ready latency

`timescale 1ns/1ps
`default_nettype none

`include "bus_defs.svh"

module cpu_bus_tb;

    import bus_pkg::*;

    localparam int clk_period   = 40;
    localparam int reset_cycles = 10;
    localparam int random_txns  = 400;
    localparam int total_txns   = 4 + `BUS_RAM_WORDS + 8 + random_txns;
    localparam int ram_aw       = $clog2(`BUS_RAM_WORDS);

    logic      clk;
    logic      arst_n;
    logic      cpu_mem_valid;
    bus_addr_t cpu_mem_address;
    bus_data_t cpu_mem_wdata;
    bus_strb_t cpu_mem_wstrb;
    logic      cpu_mem_ready;
    bus_data_t cpu_mem_rdata;
    logic      cpu_mem_error;
    bus_addr_t ext_address;
    bus_data_t ext_wdata;
    bus_strb_t ext_wstrb;
    logic      vdp_en;
    logic      vdp_write_en;
    logic      dsp_en;
    logic      dsp_write_en;
    logic      pad_en;
    logic      pad_write_en;
    logic      flash_read_en;
    bus_data_t ext_rdata;

    integer    seed;

    // model state
    bus_data_t model_ram [`BUS_RAM_WORDS];
    bus_data_t model_scratch;
    bus_data_t model_control;
    bus_data_t model_count;

    cpu_bus_top dut (
        .clk             (clk),
        .arst_n          (arst_n),
        .cpu_mem_valid   (cpu_mem_valid),
        .cpu_mem_address (cpu_mem_address),
        .cpu_mem_wdata   (cpu_mem_wdata),
        .cpu_mem_wstrb   (cpu_mem_wstrb),
        .cpu_mem_ready   (cpu_mem_ready),
        .cpu_mem_rdata   (cpu_mem_rdata),
        .cpu_mem_error   (cpu_mem_error),
        .ext_address     (ext_address),
        .ext_wdata       (ext_wdata),
        .ext_wstrb       (ext_wstrb),
        .vdp_en          (vdp_en),
        .vdp_write_en    (vdp_write_en),
        .dsp_en          (dsp_en),
        .dsp_write_en    (dsp_write_en),
        .pad_en          (pad_en),
        .pad_write_en    (pad_write_en),
        .flash_read_en   (flash_read_en),
        .ext_rdata       (ext_rdata)
    );

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    // external devices answer with a value built from the whole address
    function automatic bus_data_t ext_value(bus_addr_t addr);
        return {addr[11:0] ^ 12'hc3a, addr};
    endfunction

    assign ext_rdata = ext_value(ext_address);

    function automatic bus_data_t merge_bytes(bus_data_t old, bus_data_t wdata, bus_strb_t strb);
        bus_data_t result;
        result = old;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                result[b*8 +: 8] = wdata[b*8 +: 8];
            end
        end
        return result;
    endfunction

    function automatic region_e model_region(bus_addr_t addr);
        if (addr[19]) begin
            return region_flash;
        end
        case (addr[18:16])
            3'd0:    return region_ram;
            3'd1:    return region_vdp;
            3'd2:    return region_status;
            3'd3:    return region_dsp;
            3'd4:    return region_pad;
            default: return region_none;
        endcase
    endfunction

    // which external enable a region should raise, none for internal targets
    function automatic region_e ext_target(region_e region);
        if (region inside {region_vdp, region_dsp, region_pad, region_flash}) begin
            return region;
        end
        return region_none;
    endfunction

    function automatic region_e pick_region(logic vdp, logic dsp, logic pad, logic flash);
        if (vdp) begin
            return region_vdp;
        end
        if (dsp) begin
            return region_dsp;
        end
        if (pad) begin
            return region_pad;
        end
        if (flash) begin
            return region_flash;
        end
        return region_none;
    endfunction

    function automatic bus_data_t expected_read(bus_addr_t addr, region_e region);
        case (region)
            region_ram:  return model_ram[addr[ram_aw+1:2]];
            region_none: return '0;
            region_status: begin
                case (addr[3:2])
                    2'd0:    return model_scratch;
                    2'd1:    return model_control;
                    2'd2:    return `BUS_STATUS_ID;
                    default: return model_count;
                endcase
            end
            default:     return ext_value(addr);
        endcase
    endfunction

    task automatic model_update(bus_addr_t addr, bus_data_t wdata, bus_strb_t strb,
                                region_e region);
        if (strb != '0 && region != region_none) begin
            model_count = model_count + 32'd1;
        end
        if (strb != '0 && region == region_ram) begin
            model_ram[addr[ram_aw+1:2]] = merge_bytes(model_ram[addr[ram_aw+1:2]], wdata, strb);
        end
        if (region == region_status && addr[3:2] == 2'd0) begin
            model_scratch = merge_bytes(model_scratch, wdata, strb);
        end
        if (region == region_status && addr[3:2] == 2'd1) begin
            model_control = merge_bytes(model_control, wdata, strb);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // compare tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic check_data(bus_data_t expected, bus_data_t actual, string name);
        if (actual !== expected) begin
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_region(region_e expected, region_e actual, string name);
        if (actual !== expected) begin
            $display("FAIL %s: expected %s, actual %s", name, expected.name(), actual.name());
            $display("*** FAILED ***");
            $fatal(1, "region mismatch");
        end
    endtask

    // no strobe may be high outside a transaction
    task automatic idle_check(int cycles, bit with_rdata, string name);
        repeat (cycles) begin
            @(negedge clk);
            check_data('0, bus_data_t'({cpu_mem_ready, cpu_mem_error, vdp_en, vdp_write_en,
                                        dsp_en, dsp_write_en, pad_en, pad_write_en,
                                        flash_read_en}), {name, " strobes"});
            if (with_rdata) begin
                check_data('0, cpu_mem_rdata, {name, " rdata"});
            end
        end
    endtask

    task automatic transfer(bus_addr_t addr, bus_data_t wdata, bus_strb_t strb, string name);
        region_e   region;
        region_e   exp_we;
        region_e   seen_en;
        region_e   seen_we;
        bus_data_t expected;
        bus_data_t rdata;
        logic      error;
        logic      got_ready;
        int        cycles;
        int        en_cycles;
        int        we_cycles;
        region = model_region(addr);
        exp_we = (strb != '0 && region inside {region_vdp, region_dsp, region_pad}) ?
                 region : region_none;
        expected = expected_read(addr, region);
        seen_en = region_none;
        seen_we = region_none;
        got_ready = 1'b0;
        cycles = 0;
        en_cycles = 0;
        we_cycles = 0;
        @(posedge clk);
        #1;
        cpu_mem_valid   = 1'b1;
        cpu_mem_address = addr;
        cpu_mem_wdata   = wdata;
        cpu_mem_wstrb   = strb;
        // sampling edge
        @(posedge clk);
        while (!got_ready) begin
            @(negedge clk);
            cycles++;
            if (vdp_en || dsp_en || pad_en || flash_read_en) begin
                en_cycles = en_cycles + int'(vdp_en) + int'(dsp_en) + int'(pad_en)
                          + int'(flash_read_en);
                seen_en = pick_region(vdp_en, dsp_en, pad_en, flash_read_en);
                check_data(bus_data_t'(addr), bus_data_t'(ext_address), {name, " ext_address"});
                check_data(wdata, ext_wdata, {name, " ext_wdata"});
                check_data(bus_data_t'(strb), bus_data_t'(ext_wstrb), {name, " ext_wstrb"});
            end
            if (vdp_write_en || dsp_write_en || pad_write_en) begin
                we_cycles = we_cycles + int'(vdp_write_en) + int'(dsp_write_en)
                          + int'(pad_write_en);
                seen_we = pick_region(vdp_write_en, dsp_write_en, pad_write_en, 1'b0);
            end
            got_ready = cpu_mem_ready;
            rdata     = cpu_mem_rdata;
            error     = cpu_mem_error;
        end
        check_data(32'd2, bus_data_t'(cycles), {name, " ready latency"});
        check_data((ext_target(region) != region_none) ? 32'd1 : 32'd0,
                   bus_data_t'(en_cycles), {name, " enable cycles"});
        check_region(ext_target(region), seen_en, {name, " enable"});
        check_data((exp_we != region_none) ? 32'd1 : 32'd0,
                   bus_data_t'(we_cycles), {name, " write enable cycles"});
        check_region(exp_we, seen_we, {name, " write enable"});
        check_data(bus_data_t'(region == region_none), bus_data_t'(error), {name, " error"});
        if (strb == '0 || region == region_none) begin
            check_data(expected, rdata, {name, " rdata"});
        end
        model_update(addr, wdata, strb, region);
        // CPU drops valid in the cycle after ready
        @(posedge clk);
        #1;
        cpu_mem_valid = 1'b0;
    endtask

    task automatic random_transfer(int index);
        bus_addr_t addr;
        bus_data_t wdata;
        bus_strb_t strb;
        addr = bus_addr_t'($random(seed));
        if (($random(seed) & 3) != 0) begin
            addr[19] = 1'b0;
        end
        wdata = $random(seed);
        strb  = (($random(seed) & 1) != 0) ? bus_strb_t'($random(seed)) : '0;
        transfer(addr, wdata, strb, $sformatf("random %0d", index));
        idle_check(int'($unsigned($random(seed)) % 4), 1'b0, "gap");
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin
        bus_addr_t fill_addr;
        seed            = 32'hef560ed4;
        arst_n          = 1'b0;
        cpu_mem_valid   = 1'b0;
        cpu_mem_address = '0;
        cpu_mem_wdata   = '0;
        cpu_mem_wstrb   = '0;
        model_scratch   = '0;
        model_control   = '0;
        model_count     = '0;

        idle_check(reset_cycles, 1'b1, "in reset");
        @(posedge clk);
        #1;
        arst_n = 1'b1;
        idle_check(2, 1'b1, "after reset");

        for (int w = 0; w < 4; w++) begin
            transfer(bus_addr_t'(20'h2_0000 + w * 4), '0, '0, $sformatf("reset status %0d", w));
        end

        // whole RAM gets a known pattern before random traffic
        for (int i = 0; i < `BUS_RAM_WORDS; i++) begin
            fill_addr = bus_addr_t'(i * 4);
            transfer(fill_addr, {~fill_addr[11:0], fill_addr}, 4'hf, $sformatf("fill %0d", i));
        end

        transfer(20'h2_0000, 32'hdead_beef, 4'b0101, "scratch write");
        transfer(20'h2_0004, 32'h1234_5678, 4'b1110, "control write");
        transfer(20'h2_0008, 32'hffff_ffff, 4'hf, "id write");
        transfer(20'h2_000c, 32'hffff_ffff, 4'hf, "count write");
        for (int w = 0; w < 4; w++) begin
            transfer(bus_addr_t'(20'h2_0000 + w * 4), '0, '0, $sformatf("status read %0d", w));
        end

        for (int i = 0; i < random_txns; i++) begin
            random_transfer(i);
        end

        $display("*** PASSED ***");
        $finish;
    end

    initial begin
        #((total_txns * 10 + reset_cycles) * clk_period);
        $display("timeout: transactions did not complete in the allowed time");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- cpu_bus_top.f
+incdir+hw
hw/bus_pkg.sv
hw/cpu_bus_if.sv
hw/bus_capture.sv
hw/address_decoder.sv
hw/work_ram.sv
hw/status_regs.sv
hw/read_return.sv
hw/cpu_bus_top.sv
dv/cpu_bus_tb.sv

//--- Makefile
# Verilator build and run of the CPU bus front end testbench

SRCS := hw/bus_defs.svh $(shell grep -v '^+' cpu_bus_top.f)

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vcpu_bus_tb: cpu_bus_top.f $(SRCS)
	verilator --binary --timing -Wno-fatal --top-module cpu_bus_tb -f cpu_bus_top.f

# the simulation result is decided by the log contents
run: obj_dir/Vcpu_bus_tb
	./obj_dir/Vcpu_bus_tb > sim.log 2>&1; cat sim.log
	grep -q '^\*\*\* PASSED \*\*\*$$' sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
